// ==== sources.f ====
+incdir+test
hdl/link_pkg.sv
hdl/chan_pkg.sv
hdl/chan_arbiter.sv
hdl/frame_assembler.sv
hdl/frame_tx.sv
hdl/frame_disassembler.sv
hdl/packet_dispatcher.sv
hdl/hss_mux_link.sv
test/tb_hss_mux_link.sv

// ==== Bender.yml ====
package:
  name: hss_mux_link

sources:
  # packages ahead of the modules that import them
  - hdl/link_pkg.sv
  - hdl/chan_pkg.sv
  - hdl/chan_arbiter.sv
  - hdl/frame_assembler.sv
  - hdl/frame_tx.sv
  - hdl/frame_disassembler.sv
  - hdl/packet_dispatcher.sv
  - hdl/hss_mux_link.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_hss_mux_link.sv

// ==== test/tb_hss_mux_tasks.svh ====
// ------------------------------
// hss mux link test tasks
// lfsr stimulus, compare tasks and the
// directed tests
// ------------------------------
`ifndef TB_HSS_MUX_TASKS_SVH
`define TB_HSS_MUX_TASKS_SVH

  logic [31:0] lfsr_state = 32'hd565788d;

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic pkt_t rand_pkt();
    pkt_t p;
    for (int i = 0; i < 64; i++) begin
      p[i] = lfsr_bit();
    end
    return p;
  endfunction

  function automatic chan_id_t rand_chan();
    chan_id_t ch;
    for (int i = 0; i < 3; i++) begin
      ch[i] = lfsr_bit();
    end
    return ch;
  endfunction

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_pkt(input string name, input pkt_t got, input pkt_t want);
    if (got !== want) begin
      $display("** Error: %s = %h, expected %h at %0t", name, got, want, $time);
      err_val++;
    end
  endtask

  task automatic check_mask(input string name, input chan_mask_t got, input chan_mask_t want);
    if (got !== want) begin
      $display("** Error: %s = %h, expected %h at %0t", name, got, want, $time);
      err_val++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("** Error: %s = %h, expected %h at %0t", name, got, want, $time);
      err_val++;
    end
  endtask

  task automatic check_word(input string name, input link_word_t got, input link_word_t want);
    if (got !== want) begin
      $display("** Error: %s = %h, expected %h at %0t", name, got, want, $time);
      err_val++;
    end
  endtask

  // ------------------------------
  // helpers
  // ------------------------------
  // sync reset held low for 10 cycles
  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
  endtask

  function automatic logic all_empty();
    for (int c = 0; c < NUM_CHANS; c++) begin
      if ((src_q[c].size() != 0) || (exp_q[c].size() != 0)) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  function automatic logic others_drained(input int skip);
    for (int c = 0; c < NUM_CHANS; c++) begin
      if ((c != skip) && ((src_q[c].size() != 0) || (exp_q[c].size() != 0))) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // all sent packets delivered
  task automatic wait_idle();
    while (!all_empty()) begin
      @(negedge clk);
    end
    // trailing status pulses
    repeat (4) @(negedge clk);
  endtask

  task automatic note_counts();
    frm_base = frm_cnt;
    seq_base = seq_cnt;
  endtask

  task automatic expect_quiet();
    check_bit("frm_err pulse seen", logic'(frm_cnt != frm_base), 1'b0);
    check_bit("seq_err pulse seen", logic'(seq_cnt != seq_base), 1'b0);
    check_mask("drop seen", drop_seen, '0);
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic reset_state();
    logic       vld_seen;
    frm_hdr_t   want_hdr;
    link_word_t want_word;
    check_mask("pkt_rdy", pkt_rdy, '0);
    check_mask("opkt_vld", opkt_vld, '0);
    check_bit("frm_err", frm_err, 1'b0);
    check_bit("seq_err", seq_err, 1'b0);
    check_mask("drop", drop, '0);
    // first control word carries an empty stop bitmap
    want_hdr            = '0;
    want_hdr.ctrl.start = K_CTRL;
    want_hdr.ctrl.ftype = FRM_CTRL;
    want_word.data      = want_hdr;
    want_word.kchr      = 4'b0001;
    // first control frame within 2 cycles
    vld_seen = 1'b0;
    repeat (2) begin
      @(negedge clk);
      if (hsl_vld && !vld_seen) begin
        check_word("hsl", hsl, want_word);
      end
      vld_seen = vld_seen | hsl_vld;
    end
    check_bit("hsl_vld", vld_seen, 1'b1);
  endtask

  // pointer starts at 0 so deliveries come in channel order
  task automatic arbitration_order();
    apply_reset();
    note_counts();
    arr_q.delete();
    opkt_rdy = '1;
    for (int c = 0; c < NUM_CHANS; c++) begin
      src_q[c].push_back(rand_pkt());
    end
    wait_idle();
    if (arr_q.size() != NUM_CHANS) begin
      $display("arbitration: %0d packets delivered instead of %0d", arr_q.size(), NUM_CHANS);
      err_other++;
    end else begin
      for (int i = 0; i < NUM_CHANS; i++) begin
        check_mask($sformatf("delivery %0d channel", i),
                   chan_mask_t'(1) << arr_q[i], chan_mask_t'(1) << i);
      end
    end
    expect_quiet();
  endtask

  task automatic single_channel_loopback();
    note_counts();
    for (int c = 0; c < NUM_CHANS; c++) begin
      src_q[c].push_back(rand_pkt());
      wait_idle();
    end
    expect_quiet();
  endtask

  // channel 3 output held while its stop bit gates the far end
  task automatic output_backpressure();
    note_counts();
    opkt_rdy    = '1;
    opkt_rdy[3] = 1'b0;
    for (int i = 0; i < 6; i++) begin
      src_q[3].push_back(rand_pkt());
    end
    for (int c = 0; c < NUM_CHANS; c++) begin
      if (c != 3) begin
        src_q[c].push_back(rand_pkt());
      end
    end
    while (!others_drained(3)) begin
      @(negedge clk);
    end
    repeat (50) @(negedge clk);
    check_bit("opkt_vld[3]", opkt_vld[3], 1'b1);
    check_mask("drop seen", drop_seen, '0);
    // remaining packets follow in order after release
    opkt_rdy[3] = 1'b1;
    wait_idle();
    expect_quiet();
  endtask

  task automatic corrupted_frame();
    note_counts();
    inj_req = inj_req + 1;
    src_q[5].push_back(rand_pkt());
    while (frm_cnt == frm_base) begin
      @(negedge clk);
    end
    // discarded frame leaves nothing owed
    exp_q[5].delete();
    src_q[5].push_back(rand_pkt());
    wait_idle();
    check_bit("one frm_err pulse", logic'((frm_cnt - frm_base) == 1), 1'b1);
    check_bit("one seq_err pulse", logic'((seq_cnt - seq_base) == 1), 1'b1);
    check_mask("drop seen", drop_seen, '0);
  endtask

  task automatic link_stalls();
    chan_id_t ch;
    note_counts();
    for (int i = 0; i < 40; i++) begin
      ch = rand_chan();
      src_q[ch].push_back(rand_pkt());
    end
    // link ready from one lfsr bit per cycle
    while (!all_empty()) begin
      @(negedge clk);
      hsl_rdy = lfsr_bit();
    end
    hsl_rdy = 1'b1;
    wait_idle();
    expect_quiet();
  endtask

`endif

// ==== test/tb_hss_mux_link.sv ====
// ------------------------------
// hss mux link testbench
// outgoing link looped back with payload
// error injection, scoreboard per channel
// ------------------------------
`timescale 1ns/1ps
module tb_hss_mux_link
  import link_pkg::*;
  import chan_pkg::*;
();

  localparam int QUEUE_DEPTH = 4;
  // packets over all tests, sets the run limit
  localparam int TOTAL_PKTS  = 8 + 8 + 13 + 2 + 40;
  localparam int CYCLE_LIMIT = TOTAL_PKTS * 20 + 2000;

  logic       clk      = 1'b0;
  logic       rst_n    = 1'b0;
  pkt_t       pkt_data [NUM_CHANS] = '{default: '0};
  chan_mask_t pkt_vld  = '0;
  chan_mask_t pkt_rdy;
  pkt_t       opkt_data [NUM_CHANS];
  chan_mask_t opkt_vld;
  chan_mask_t opkt_rdy = '1;
  link_word_t hsl;
  logic       hsl_vld;
  logic       hsl_rdy  = 1'b1;
  link_word_t ihsl;
  logic       ihsl_vld;
  logic       frm_err;
  logic       seq_err;
  chan_mask_t drop;

  // ------------------------------
  // scoreboard state
  // ------------------------------
  // packets waiting at the inputs, and accepted ones still owed at the outputs
  pkt_t       src_q [NUM_CHANS][$];
  pkt_t       exp_q [NUM_CHANS][$];
  // output channel of each delivery, in order
  chan_id_t   arr_q [$];
  // status pulse counts, bases taken at test start
  int         frm_cnt   = 0;
  int         seq_cnt   = 0;
  int         frm_base  = 0;
  int         seq_base  = 0;
  chan_mask_t drop_seen = '0;
  // bit flips asked for and done
  int         inj_req   = 0;
  int         inj_done  = 0;
  int         err_val   = 0;
  int         err_other = 0;
  int         cycles    = 0;

  `include "tb_hss_mux_tasks.svh"

  hss_mux_link #(
    .NUM_CHANS   (NUM_CHANS),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .pkt_data  (pkt_data),
    .pkt_vld   (pkt_vld),
    .pkt_rdy   (pkt_rdy),
    .opkt_data (opkt_data),
    .opkt_vld  (opkt_vld),
    .opkt_rdy  (opkt_rdy),
    .hsl       (hsl),
    .hsl_vld   (hsl_vld),
    .hsl_rdy   (hsl_rdy),
    .ihsl      (ihsl),
    .ihsl_vld  (ihsl_vld),
    .frm_err   (frm_err),
    .seq_err   (seq_err),
    .drop      (drop)
  );

  always #5 clk = ~clk;

  // loopback, words pass only when taken
  always_comb begin
    ihsl     = hsl;
    ihsl_vld = hsl_vld && hsl_rdy;
    // flip bit 0 of the next non-K word
    if ((inj_req != inj_done) && (hsl.kchr == 4'b0000)) begin
      ihsl.data[0] = ~hsl.data[0];
    end
  end

  // flip used up once the word is taken
  always @(posedge clk) begin
    if ((inj_req != inj_done) && hsl_vld && hsl_rdy && (hsl.kchr == 4'b0000)) begin
      inj_done <= inj_done + 1;
    end
  end

  // packet sources show their queue heads
  always @(negedge clk) begin
    for (int c = 0; c < NUM_CHANS; c++) begin
      pkt_vld[c]  = (src_q[c].size() != 0);
      pkt_data[c] = pkt_vld[c] ? src_q[c][0] : '0;
    end
  end

  // ------------------------------
  // monitor
  // ------------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      for (int c = 0; c < NUM_CHANS; c++) begin
        // accepted input becomes owed output
        if (pkt_vld[c] && pkt_rdy[c] && (src_q[c].size() != 0)) begin
          exp_q[c].push_back(src_q[c].pop_front());
        end
        if (opkt_vld[c] && opkt_rdy[c]) begin
          if (exp_q[c].size() == 0) begin
            $display("unexpected packet %h on channel %0d at %0t", opkt_data[c], c, $time);
            err_other++;
          end else begin
            check_pkt($sformatf("opkt_data[%0d]", c), opkt_data[c], exp_q[c].pop_front());
          end
          arr_q.push_back(chan_id_t'(c));
        end
      end
      if (frm_err) begin
        frm_cnt++;
      end
      if (seq_err) begin
        seq_cnt++;
      end
      drop_seen = drop_seen | drop;
    end
  end

  // closing line, then the verdict
  task automatic finish_run(input logic timed_out);
    $display("error count: %0d value errors, %0d other errors", err_val, err_other);
    if (!timed_out && (err_val == 0) && (err_other == 0)) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
      err_other++;
      finish_run(1'b1);
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    apply_reset();
    reset_state();
    arbitration_order();
    single_channel_loopback();
    output_backpressure();
    corrupted_frame();
    link_stalls();
    finish_run(1'b0);
  end

endmodule

// ==== hdl/hss_mux_link.sv ====
// ------------------------------
// hss multiplexer top level
// joins the transmit and receive paths
// ------------------------------
`timescale 1ns/1ps
module hss_mux_link
  import link_pkg::*;
  import chan_pkg::*;
#(
  parameter int NUM_CHANS   = chan_pkg::NUM_CHANS,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic       clk,
  input  logic       rst_n,

  // packet inputs
  input  pkt_t       pkt_data [NUM_CHANS],
  input  chan_mask_t pkt_vld,
  output chan_mask_t pkt_rdy,

  // packet outputs
  output pkt_t       opkt_data [NUM_CHANS],
  output chan_mask_t opkt_vld,
  input  chan_mask_t opkt_rdy,

  // outgoing link
  output link_word_t hsl,
  output logic       hsl_vld,
  input  logic       hsl_rdy,

  // incoming link
  input  link_word_t ihsl,
  input  logic       ihsl_vld,

  // status pulses
  output logic       frm_err,
  output logic       seq_err,
  output chan_mask_t drop
);

  // assembler to transmitter
  frm_word_t  frm;
  logic       frm_vld;
  logic       frm_rdy;

  // stop bitmaps, remote and local
  chan_mask_t cfc_rem;
  chan_mask_t cfc_loc;

  // disassembler to dispatcher
  pkt_t       ipkt;
  chan_id_t   ipkt_chan;
  logic       ipkt_vld;

  // ------------------------------
  // transmit path
  // ------------------------------
  frame_assembler #(
    .NUM_CHANS (NUM_CHANS)
  ) fa_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .cfc_rem  (cfc_rem),
    .frm      (frm),
    .frm_vld  (frm_vld),
    .frm_rdy  (frm_rdy)
  );

  frame_tx ft_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .frm     (frm),
    .frm_vld (frm_vld),
    .frm_rdy (frm_rdy),
    .cfc_loc (cfc_loc),
    .hsl     (hsl),
    .hsl_vld (hsl_vld),
    .hsl_rdy (hsl_rdy)
  );

  // ------------------------------
  // receive path
  // ------------------------------
  frame_disassembler fd_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ihsl      (ihsl),
    .ihsl_vld  (ihsl_vld),
    .ipkt      (ipkt),
    .ipkt_chan (ipkt_chan),
    .ipkt_vld  (ipkt_vld),
    .cfc_rem   (cfc_rem),
    .frm_err   (frm_err),
    .seq_err   (seq_err)
  );

  packet_dispatcher #(
    .NUM_CHANS   (NUM_CHANS),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) pd_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ipkt      (ipkt),
    .ipkt_chan (ipkt_chan),
    .ipkt_vld  (ipkt_vld),
    .opkt_data (opkt_data),
    .opkt_vld  (opkt_vld),
    .opkt_rdy  (opkt_rdy),
    .cfc_loc   (cfc_loc),
    .drop      (drop)
  );

endmodule

// ==== hdl/packet_dispatcher.sv ====
// ------------------------------
// packet dispatcher
// per-channel output queues, local stop
// bitmap and drop reporting
// ------------------------------
`timescale 1ns/1ps
module packet_dispatcher
  import chan_pkg::*;
#(
  parameter int NUM_CHANS   = chan_pkg::NUM_CHANS,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic       clk,
  input  logic       rst_n,

  // packets from the disassembler
  input  pkt_t       ipkt,
  input  chan_id_t   ipkt_chan,
  input  logic       ipkt_vld,

  // packet outputs
  output pkt_t       opkt_data [NUM_CHANS],
  output chan_mask_t opkt_vld,
  input  chan_mask_t opkt_rdy,

  output chan_mask_t cfc_loc,
  output chan_mask_t drop
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  pkt_t                 mem [NUM_CHANS][QUEUE_DEPTH];
  logic [PTR_W-1:0]     rd_ptr [NUM_CHANS];
  logic [PTR_W-1:0]     wr_ptr [NUM_CHANS];
  logic [CNT_W-1:0]     count [NUM_CHANS];
  logic [NUM_CHANS-1:0] wr;
  logic [NUM_CHANS-1:0] rd;
  logic [NUM_CHANS-1:0] full;
  logic [NUM_CHANS-1:0] vld;
  logic [NUM_CHANS-1:0] stop;
  logic [NUM_CHANS-1:0] dropping;

  // circular pointer step
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // ------------------------------
  // queue status
  // ------------------------------
  always_comb begin
    for (int c = 0; c < NUM_CHANS; c++) begin
      vld[c]       = (count[c] != '0);
      full[c]      = (count[c] == CNT_W'(QUEUE_DEPTH));
      wr[c]        = ipkt_vld && (ipkt_chan == chan_id_t'(c)) && !full[c];
      dropping[c]  = ipkt_vld && (ipkt_chan == chan_id_t'(c)) && full[c];
      rd[c]        = vld[c] && opkt_rdy[c];
      // stop early, frames already in flight still land
      stop[c]      = (count[c] >= CNT_W'(QUEUE_DEPTH - 2));
      opkt_data[c] = mem[c][rd_ptr[c]];
    end
  end

  // unused channel bits stay zero
  assign opkt_vld = chan_mask_t'(vld);
  assign cfc_loc  = chan_mask_t'(stop);

  // pointers, counts and drop pulses
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      drop <= '0;
      for (int c = 0; c < NUM_CHANS; c++) begin
        rd_ptr[c] <= '0;
        wr_ptr[c] <= '0;
        count[c]  <= '0;
      end
    end else begin
      drop <= chan_mask_t'(dropping);
      for (int c = 0; c < NUM_CHANS; c++) begin
        if (wr[c]) begin
          wr_ptr[c] <= next_ptr(wr_ptr[c]);
        end
        if (rd[c]) begin
          rd_ptr[c] <= next_ptr(rd_ptr[c]);
        end
        if (wr[c] && !rd[c]) begin
          count[c] <= count[c] + 1'b1;
        end else if (rd[c] && !wr[c]) begin
          count[c] <= count[c] - 1'b1;
        end
      end
    end
  end

  // queue storage
  always_ff @(posedge clk) begin
    for (int c = 0; c < NUM_CHANS; c++) begin
      if (wr[c]) begin
        mem[c][wr_ptr[c]] <= ipkt;
      end
    end
  end

endmodule

// ==== hdl/frame_disassembler.sv ====
// ------------------------------
// frame disassembler
// checks incoming frames, splits off
// packets and remote stop bitmaps
// ------------------------------
`timescale 1ns/1ps
module frame_disassembler
  import link_pkg::*;
  import chan_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // incoming link, no back-pressure
  input  link_word_t ihsl,
  input  logic       ihsl_vld,

  // received packets
  output pkt_t       ipkt,
  output chan_id_t   ipkt_chan,
  output logic       ipkt_vld,

  // remote stop bitmap
  output chan_mask_t cfc_rem,

  // status pulses
  output logic       frm_err,
  output logic       seq_err
);

  frm_hdr_t            hdr_in;
  frm_hdr_t            hdr_q;
  logic                busy;
  logic [1:0]          cnt;
  logic [CHK_BITS-1:0] acc;
  logic [31:0]         pld_hi;
  logic [31:0]         pld_lo;
  seq_t                exp_seq;
  logic                is_data_hdr;
  logic                is_ctrl_hdr;
  logic                chk_ok;

  // incoming word seen as a header
  assign hdr_in = ihsl.data;

  assign is_data_hdr = (ihsl.kchr == 4'b0001) &&
                       (hdr_in.data.start == K_DATA) &&
                       (hdr_in.data.ftype == FRM_DATA);
  assign is_ctrl_hdr = (ihsl.kchr == 4'b0001) &&
                       (hdr_in.ctrl.start == K_CTRL) &&
                       (hdr_in.ctrl.ftype == FRM_CTRL);

  // trailer against running xor
  assign chk_ok = (ihsl.data == acc);

  // ------------------------------
  // frame state and status
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      cnt      <= '0;
      exp_seq  <= '0;
      cfc_rem  <= '0;
      ipkt_vld <= 1'b0;
      frm_err  <= 1'b0;
      seq_err  <= 1'b0;
    end else begin
      ipkt_vld <= 1'b0;
      frm_err  <= 1'b0;
      seq_err  <= 1'b0;
      if (ihsl_vld) begin
        if (!busy) begin
          // hunting for a start code
          if (is_data_hdr) begin
            busy <= 1'b1;
            cnt  <= 2'd1;
          end else if (is_ctrl_hdr) begin
            cfc_rem <= hdr_in.ctrl.stop;
          end
        end else if (ihsl.kchr != 4'b0000) begin
          // K char inside a frame, drop it
          busy    <= 1'b0;
          frm_err <= 1'b1;
        end else if (cnt == 2'd3) begin
          busy <= 1'b0;
          if (!chk_ok) begin
            frm_err <= 1'b1;
          end else begin
            // out of order still delivered
            ipkt_vld <= 1'b1;
            seq_err  <= (hdr_q.data.seq != exp_seq);
            exp_seq  <= hdr_q.data.seq + 1'b1;
          end
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // header, payload and checksum collection
  always_ff @(posedge clk) begin
    if (ihsl_vld) begin
      if (!busy) begin
        hdr_q <= hdr_in;
        acc   <= ihsl.data;
      end else begin
        acc <= acc ^ ihsl.data;
        if (cnt == 2'd1) begin
          pld_hi <= ihsl.data;
        end
        if (cnt == 2'd2) begin
          pld_lo <= ihsl.data;
        end
        if (cnt == 2'd3) begin
          ipkt      <= {pld_hi, pld_lo};
          ipkt_chan <= hdr_q.data.chan;
        end
      end
    end
  end

endmodule

// ==== hdl/frame_tx.sv ====
// ------------------------------
// frame transmitter
// merges data and control frames onto
// the outgoing link, one register stage
// ------------------------------
`timescale 1ns/1ps
module frame_tx
  import link_pkg::*;
  import chan_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // frames from the assembler
  input  frm_word_t  frm,
  input  logic       frm_vld,
  output logic       frm_rdy,

  // local stop bitmap
  input  chan_mask_t cfc_loc,

  // outgoing link
  output link_word_t hsl,
  output logic       hsl_vld,
  input  logic       hsl_rdy
);

  logic       out_free;
  logic       in_frame;
  logic       pend_q;
  logic       pend;
  chan_mask_t cfc_sent;
  logic       send_ctrl;
  logic       take_data;
  frm_hdr_t   ctrl_hdr;

  // output register empty or being taken
  assign out_free = !hsl_vld || hsl_rdy;

  // new bitmap or still owed since reset
  assign pend = pend_q || (cfc_loc != cfc_sent);

  // control only between data frames
  assign send_ctrl = out_free && !in_frame && pend;

  // data held off while a control word goes out
  assign frm_rdy   = out_free && !send_ctrl;
  assign take_data = frm_vld && frm_rdy;

  // control word with the current bitmap
  always_comb begin
    ctrl_hdr            = '0;
    ctrl_hdr.ctrl.start = K_CTRL;
    ctrl_hdr.ctrl.ftype = FRM_CTRL;
    ctrl_hdr.ctrl.stop  = cfc_loc;
  end

  // ------------------------------
  // control state
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hsl_vld  <= 1'b0;
      in_frame <= 1'b0;
      pend_q   <= 1'b1;
      cfc_sent <= '0;
    end else if (send_ctrl) begin
      hsl_vld  <= 1'b1;
      pend_q   <= 1'b0;
      cfc_sent <= cfc_loc;
    end else if (take_data) begin
      hsl_vld  <= 1'b1;
      // frame boundary follows the last word
      in_frame <= !frm.last;
    end else if (out_free) begin
      hsl_vld  <= 1'b0;
    end
  end

  // output word
  always_ff @(posedge clk) begin
    if (send_ctrl) begin
      hsl.data <= ctrl_hdr;
      hsl.kchr <= 4'b0001;
    end else if (take_data) begin
      hsl <= frm.word;
    end
  end

endmodule

// ==== hdl/frame_assembler.sv ====
// ------------------------------
// frame assembler
// takes the granted packet and builds a
// four-word data frame
// ------------------------------
`timescale 1ns/1ps
module frame_assembler
  import link_pkg::*;
  import chan_pkg::*;
#(
  parameter int NUM_CHANS = chan_pkg::NUM_CHANS
) (
  input  logic       clk,
  input  logic       rst_n,

  // packet inputs
  input  pkt_t       pkt_data [NUM_CHANS],
  input  chan_mask_t pkt_vld,
  output chan_mask_t pkt_rdy,

  // remote stop bitmap
  input  chan_mask_t cfc_rem,

  // frame output
  output frm_word_t  frm,
  output logic       frm_vld,
  input  logic       frm_rdy
);

  chan_mask_t          req;
  chan_mask_t          gnt;
  chan_id_t            gnt_id;
  logic                take;
  logic                busy;
  logic [1:0]          widx;
  seq_t                tx_seq;
  frm_hdr_t            hdr_new;
  frm_hdr_t            hdr_q;
  pkt_t                pkt_q;
  logic [CHK_BITS-1:0] chk;

  // ------------------------------
  // arbitration
  // ------------------------------
  // eligible unless the far end asked to stop
  assign req = pkt_vld & ~cfc_rem;

  chan_arbiter #(
    .NUM_CHANS (NUM_CHANS)
  ) arb_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .take  (take),
    .gnt   (gnt)
  );

  // one-hot grant to channel number
  always_comb begin
    gnt_id = '0;
    for (int i = 0; i < NUM_CHANS; i++) begin
      if (gnt[i]) begin
        gnt_id = chan_id_t'(i);
      end
    end
  end

  // ready only toward the winner, only while idle
  assign pkt_rdy = busy ? '0 : gnt;
  assign take    = !busy && (gnt != '0);

  // header for the packet being captured
  always_comb begin
    hdr_new            = '0;
    hdr_new.data.start = K_DATA;
    hdr_new.data.ftype = FRM_DATA;
    hdr_new.data.chan  = gnt_id;
    hdr_new.data.seq   = tx_seq;
  end

  // ------------------------------
  // frame sequencing
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      widx   <= '0;
      tx_seq <= '0;
    end else if (take) begin
      busy   <= 1'b1;
      widx   <= '0;
      tx_seq <= tx_seq + 1'b1;
    end else if (frm_vld && frm_rdy) begin
      // back to idle after the trailer
      if (widx == 2'd3) begin
        busy <= 1'b0;
      end
      widx <= widx + 1'b1;
    end
  end

  // captured packet and header
  always_ff @(posedge clk) begin
    if (take) begin
      pkt_q <= pkt_data[gnt_id];
      hdr_q <= hdr_new;
    end
  end

  // trailer over header and both payload words
  assign chk = hdr_q ^ pkt_q[63:32] ^ pkt_q[31:0];

  assign frm_vld = busy;

  // word mux, K flag on the header only
  always_comb begin
    frm.word.kchr = 4'b0000;
    frm.last      = 1'b0;
    case (widx)
      2'd0: begin
        frm.word.data = hdr_q;
        frm.word.kchr = 4'b0001;
      end
      2'd1: frm.word.data = pkt_q[63:32];
      2'd2: frm.word.data = pkt_q[31:0];
      default: begin
        frm.word.data = chk;
        frm.last      = 1'b1;
      end
    endcase
  end

endmodule

// ==== hdl/chan_arbiter.sv ====
// ------------------------------
// channel arbiter
// round-robin grant among eligible channels
// ------------------------------
`timescale 1ns/1ps
module chan_arbiter
  import chan_pkg::*;
#(
  parameter int NUM_CHANS = chan_pkg::NUM_CHANS
) (
  input  logic       clk,
  input  logic       rst_n,
  input  chan_mask_t req,
  input  logic       take,
  output chan_mask_t gnt
);

  // search start, one past last winner
  chan_id_t ptr;
  chan_id_t gnt_id;
  logic     found;

  // first requester at or after ptr
  always_comb begin
    int idx;
    gnt    = '0;
    gnt_id = '0;
    found  = 1'b0;
    for (int i = 0; i < NUM_CHANS; i++) begin
      idx = int'(ptr) + i;
      // wrap around the channel count
      if (idx >= NUM_CHANS) begin
        idx = idx - NUM_CHANS;
      end
      if (!found && req[idx]) begin
        found    = 1'b1;
        gnt[idx] = 1'b1;
        gnt_id   = chan_id_t'(idx);
      end
    end
  end

  // pointer moves only when the grant is used
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (take && found) begin
      if (gnt_id == chan_id_t'(NUM_CHANS - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= gnt_id + 1'b1;
      end
    end
  end

endmodule

// ==== hdl/chan_pkg.sv ====
// ------------------------------
// channel package
// packet and channel types shared by
// the packet-side blocks
// ------------------------------
package chan_pkg;

  // default channel count, header field allows up to 8
  localparam int NUM_CHANS = 8;

  // one packet, moved whole
  typedef logic [63:0] pkt_t;

  // channel number as carried in the header
  typedef logic [2:0] chan_id_t;

  // one bit per channel
  // stop bitmaps, valid and ready vectors
  typedef logic [7:0] chan_mask_t;

endpackage

// ==== hdl/link_pkg.sv ====
// ------------------------------
// link format package
// link word, K codes, frame header views
// and checksum width of the serial link
// ------------------------------
package link_pkg;

  // one link word, kchr flags each byte as K character
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  kchr;
  } link_word_t;

  // byte-0 start codes
  localparam logic [7:0] K_DATA = 8'hbc;
  localparam logic [7:0] K_CTRL = 8'h3c;

  // trailer width, plain xor over frame words
  localparam int CHK_BITS = 32;

  typedef logic [7:0] seq_t;

  typedef enum logic {
    FRM_DATA = 1'b0,
    FRM_CTRL = 1'b1
  } frm_type_e;

  // data frame header
  typedef struct packed {
    logic [11:0] spare;
    seq_t        seq;
    logic [2:0]  chan;
    frm_type_e   ftype;
    logic [7:0]  start;
  } data_hdr_t;

  // control word, carries stop bitmap
  typedef struct packed {
    logic [14:0] spare;
    logic [7:0]  stop;
    frm_type_e   ftype;
    logic [7:0]  start;
  } ctrl_hdr_t;

  // same header word, decoded two ways
  typedef union packed {
    data_hdr_t data;
    ctrl_hdr_t ctrl;
  } frm_hdr_t;

  // assembler to transmitter word
  typedef struct packed {
    link_word_t word;
    logic       last;
  } frm_word_t;

endpackage
